// ==== src.f ====
design/mem_msg_pkg.sv
design/sec_pkg.sv
design/resp_ingress.sv
design/resp_queue.sv
design/resp_access_filter.sv
design/proc_resp_path.sv
sim/proc_resp_path_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = proc_resp_path_tb
FILELIST = src.f
LOG      = sim.log
PASS_MSG = Everything OK

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sim/proc_resp_path_tb.sv ====
// testbench for the processor response path with random traffic from a fixed seed
// a queue model in the testbench predicts every processor response and the deny count
// run through the Makefile in the project root

module proc_resp_path_tb;

	localparam int CLK_PERIOD     = 8;
	localparam int RESET_CYCLES   = 10;
	localparam int PHASE_RESP     = 200;
	localparam int NUM_PHASES     = 4;
	localparam int TOTAL_RESP     = PHASE_RESP * NUM_PHASES;
	localparam int TIMEOUT_CYCLES = TOTAL_RESP * 40 + 1000;

	logic                   clk;
	logic                   arst_n;
	logic                   net_resp_val;
	logic                   net_resp_rdy;
	mem_msg_pkg::resp_msg_t net_resp_msg;
	sec_pkg::sec_level_t    net_resp_sec;
	logic                   net_resp_fail;
	sec_pkg::sec_level_t    proc_sec_level;
	logic                   proc_resp_val;
	logic                   proc_resp_rdy;
	mem_msg_pkg::resp_msg_t proc_resp_msg;
	logic                   proc_resp_fail;
	sec_pkg::deny_count_t   deny_count;

	integer seed;
	int     errors;
	int     checks;
	int     sent_total;
	int     recv_total;
	int     denied_model;

	// reference model holds one entry per accepted network transfer
	mem_msg_pkg::resp_msg_t msg_q [$];
	sec_pkg::sec_level_t    sec_q [$];
	logic                   fail_q [$];

	proc_resp_path u_dut (
		.clk            (clk),
		.arst_n         (arst_n),
		.net_resp_val   (net_resp_val),
		.net_resp_rdy   (net_resp_rdy),
		.net_resp_msg   (net_resp_msg),
		.net_resp_sec   (net_resp_sec),
		.net_resp_fail  (net_resp_fail),
		.proc_sec_level (proc_sec_level),
		.proc_resp_val  (proc_resp_val),
		.proc_resp_rdy  (proc_resp_rdy),
		.proc_resp_msg  (proc_resp_msg),
		.proc_resp_fail (proc_resp_fail),
		.deny_count     (deny_count)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//==================================================
	// traffic phase
	//==================================================

	// outputs sampled on the falling edge and inputs driven on the rising edge
	task automatic run_phase(input string name, input sec_pkg::sec_level_t level,
			input bit long_stalls);
		int                     offered;
		int                     idle;
		int                     stall_left;
		bit                     offer_open;
		bit                     net_fire;
		bit                     proc_fire;
		bit                     saw_rdy_low;
		logic [31:0]            rnd;
		mem_msg_pkg::resp_msg_t new_msg;
		mem_msg_pkg::resp_msg_t exp_msg;
		sec_pkg::sec_level_t    resp_sec;
		logic                   exp_fail;

		offered     = 0;
		idle        = 0;
		stall_left  = 0;
		offer_open  = 0;
		saw_rdy_low = 0;
		// path is drained here, so the new level applies to every response of the phase
		@(posedge clk);
		proc_sec_level <= level;
		while (offered < PHASE_RESP || offer_open || msg_q.size() != 0 || idle < 8) begin
			@(negedge clk);
			net_fire  = net_resp_val && net_resp_rdy;
			proc_fire = proc_resp_val && proc_resp_rdy;
			if (!net_resp_rdy)
				saw_rdy_low = 1;
			idle = proc_resp_val ? 0 : idle + 1;
			if (net_fire) begin
				msg_q.push_back(net_resp_msg);
				sec_q.push_back(net_resp_sec);
				fail_q.push_back(net_resp_fail);
				sent_total++;
				offer_open = 0;
			end
			// every processor transfer counts, expected or not
			if (proc_fire)
				recv_total++;
			if (proc_fire && msg_q.size() == 0) begin
				errors++;
				$display("%s: processor response arrived with nothing outstanding", name);
			end else if (proc_fire) begin
				exp_msg  = msg_q.pop_front();
				resp_sec = sec_q.pop_front();
				exp_fail = fail_q.pop_front();
				// a level above the processor withholds data and fail but keeps the header
				if (resp_sec > level) begin
					exp_msg.data = '0;
					exp_fail     = 1'b0;
					denied_model++;
				end
				checks++;
				if (proc_resp_msg !== exp_msg) begin
					errors++;
					$display("FAILED %s msg: expected %h, actual %h", name, exp_msg,
						proc_resp_msg);
				end
				if (proc_resp_fail !== exp_fail) begin
					errors++;
					$display("FAILED %s fail: expected %b, actual %b", name, exp_fail,
						proc_resp_fail);
				end
			end
			@(posedge clk);
			// a pending network offer is held until it is taken
			rnd = $random(seed);
			if (!offer_open && offered < PHASE_RESP && rnd[0]) begin
				new_msg.msg_type = rnd[3:1];
				new_msg.opaque   = rnd[11:4];
				new_msg.len      = rnd[13:12];
				new_msg.data     = $random(seed);
				net_resp_val  <= 1'b1;
				net_resp_msg  <= new_msg;
				net_resp_sec  <= rnd[14];
				net_resp_fail <= rnd[15];
				offer_open = 1;
				offered++;
			end else if (!offer_open) begin
				net_resp_val <= 1'b0;
			end
			// processor side ready
			rnd = $random(seed);
			if (long_stalls && stall_left > 0) begin
				stall_left--;
				proc_resp_rdy <= 1'b0;
			end else if (long_stalls && rnd[3:0] == 4'h0) begin
				stall_left = 10 + int'(rnd[8:4]);
				proc_resp_rdy <= 1'b0;
			end else if (long_stalls) begin
				proc_resp_rdy <= 1'b1;
			end else begin
				proc_resp_rdy <= (rnd[1:0] != 2'b00);
			end
		end
		if (long_stalls && !saw_rdy_low) begin
			errors++;
			$display("%s: net_resp_rdy never dropped while the processor stalled", name);
		end
		@(negedge clk);
		checks++;
		if (deny_count !== sec_pkg::deny_count_t'(denied_model)) begin
			errors++;
			$display("FAILED %s deny_count: expected %0d, actual %0d", name, denied_model,
				deny_count);
		end
	endtask

	//==================================================
	// main sequence
	//==================================================

	initial begin
		logic [31:0] rnd;

		seed           = 32'hb1d5996c;
		errors         = 0;
		checks         = 0;
		sent_total     = 0;
		recv_total     = 0;
		denied_model   = 0;
		clk            = 1'b0;
		arst_n         = 1'b0;
		net_resp_val   = 1'b0;
		net_resp_msg   = '0;
		net_resp_sec   = sec_pkg::SEC_NORMAL;
		net_resp_fail  = 1'b0;
		proc_sec_level = sec_pkg::SEC_SECURE;
		proc_resp_rdy  = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		// idle state straight out of reset
		@(negedge clk);
		checks++;
		if (proc_resp_val !== 1'b0 || net_resp_rdy !== 1'b1 || deny_count !== '0) begin
			errors++;
			$display("FAILED reset val/rdy/count: expected 0/1/0, actual %b/%b/%0d",
				proc_resp_val, net_resp_rdy, deny_count);
		end

		run_phase("pass_through", sec_pkg::SEC_SECURE, 1'b0);
		run_phase("denial", sec_pkg::SEC_NORMAL, 1'b0);
		rnd = $random(seed);
		run_phase("back_pressure", rnd[0], 1'b1);
		rnd = $random(seed);
		run_phase("mixed", rnd[0], 1'b0);

		if (recv_total != sent_total) begin
			errors++;
			$display("sent %0d responses but the processor received %0d",
				sent_total, recv_total);
		end
		$display("checks: %0d  errors: %0d  sent: %0d  received: %0d  denied: %0d",
			checks, errors, sent_total, recv_total, denied_model);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog sized from the total traffic of all phases
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, %0d of %0d responses received",
			TIMEOUT_CYCLES, recv_total, TOTAL_RESP);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== design/proc_resp_path.sv ====
// memory response path of one core, network edge to processor
// ingress register, response queue, then the security access filter

module proc_resp_path #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     arst_n,

	// network side
	input  logic                     net_resp_val,
	output logic                     net_resp_rdy,
	input  mem_msg_pkg::resp_msg_t   net_resp_msg,
	input  sec_pkg::sec_level_t      net_resp_sec,
	input  logic                     net_resp_fail,

	// processor mode
	input  sec_pkg::sec_level_t      proc_sec_level,

	// processor side
	output logic                     proc_resp_val,
	input  logic                     proc_resp_rdy,
	output mem_msg_pkg::resp_msg_t   proc_resp_msg,
	output logic                     proc_resp_fail,

	output sec_pkg::deny_count_t     deny_count
);

	// ingress to queue
	logic                   enq_val;
	logic                   enq_rdy;
	mem_msg_pkg::resp_msg_t enq_msg;
	sec_pkg::sec_level_t    enq_sec;
	logic                   enq_fail;

	// queue to filter
	logic                   deq_val;
	logic                   deq_rdy;
	mem_msg_pkg::resp_msg_t deq_msg;
	sec_pkg::sec_level_t    deq_sec;
	logic                   deq_fail;

	resp_ingress u_ingress (
		.clk           (clk),
		.arst_n        (arst_n),
		.net_resp_val  (net_resp_val),
		.net_resp_rdy  (net_resp_rdy),
		.net_resp_msg  (net_resp_msg),
		.net_resp_sec  (net_resp_sec),
		.net_resp_fail (net_resp_fail),
		.enq_val       (enq_val),
		.enq_rdy       (enq_rdy),
		.enq_msg       (enq_msg),
		.enq_sec       (enq_sec),
		.enq_fail      (enq_fail)
	);

	resp_queue #(
		.DEPTH (QUEUE_DEPTH)
	) u_queue (
		.clk      (clk),
		.arst_n   (arst_n),
		.enq_val  (enq_val),
		.enq_rdy  (enq_rdy),
		.enq_msg  (enq_msg),
		.enq_sec  (enq_sec),
		.enq_fail (enq_fail),
		.deq_val  (deq_val),
		.deq_rdy  (deq_rdy),
		.deq_msg  (deq_msg),
		.deq_sec  (deq_sec),
		.deq_fail (deq_fail)
	);

	resp_access_filter u_filter (
		.clk            (clk),
		.arst_n         (arst_n),
		.proc_sec_level (proc_sec_level),
		.deq_val        (deq_val),
		.deq_rdy        (deq_rdy),
		.deq_msg        (deq_msg),
		.deq_sec        (deq_sec),
		.deq_fail       (deq_fail),
		.proc_resp_val  (proc_resp_val),
		.proc_resp_rdy  (proc_resp_rdy),
		.proc_resp_msg  (proc_resp_msg),
		.proc_resp_fail (proc_resp_fail),
		.deny_count     (deny_count)
	);

endmodule

// ==== design/resp_access_filter.sv ====
// security access filter on the response path toward the processor
// withholds data of responses above the processor level and counts them

module resp_access_filter (
	input  logic                     clk,
	input  logic                     arst_n,

	// current processor mode
	input  sec_pkg::sec_level_t      proc_sec_level,

	// from the response queue
	input  logic                     deq_val,
	output logic                     deq_rdy,
	input  mem_msg_pkg::resp_msg_t   deq_msg,
	input  sec_pkg::sec_level_t      deq_sec,
	input  logic                     deq_fail,

	// toward the processor
	output logic                     proc_resp_val,
	input  logic                     proc_resp_rdy,
	output mem_msg_pkg::resp_msg_t   proc_resp_msg,
	output logic                     proc_resp_fail,

	// status for software
	output sec_pkg::deny_count_t     deny_count
);

	logic                   deq_fire;
	logic                   deny;
	mem_msg_pkg::resp_msg_t filt_msg;

	// registered decision kept alongside the output beat
	logic                   out_denied;

	// output register frees up when empty or being taken now
	assign deq_rdy  = !proc_resp_val || proc_resp_rdy;
	assign deq_fire = deq_val && deq_rdy;

	// only a secure response seen by a normal-mode processor is denied
	assign deny = (deq_sec == sec_pkg::SEC_SECURE) && (proc_sec_level == sec_pkg::SEC_NORMAL);

	//==================================================
	// filter datapath
	//==================================================

	// type, opaque and length survive so the processor can retire the request
	always_comb begin
		filt_msg = deq_msg;
		if (deny)
			filt_msg.data = '0;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			proc_resp_val <= 1'b0;
			deny_count    <= '0;
		end else begin
			if (deq_fire)
				proc_resp_val <= 1'b1;
			else if (proc_resp_rdy)
				proc_resp_val <= 1'b0;
			// saturating count of withheld responses
			if (deq_fire && deny && deny_count != '1)
				deny_count <= deny_count + 1'b1;
		end
	end

	// output payload
	always_ff @(posedge clk) begin
		if (deq_fire) begin
			proc_resp_msg  <= filt_msg;
			proc_resp_fail <= deny ? 1'b0 : deq_fail;
			out_denied     <= deny;
		end
	end

	// denied data never leaves the filter
	a_denied_zero: assert property (@(posedge clk) disable iff (!arst_n)
		proc_resp_val && out_denied |-> proc_resp_msg.data == '0 && !proc_resp_fail)
		else $error("denied response carries data or a fail flag");

endmodule

// ==== design/resp_queue.sv ====
// response queue between the ingress register and the access filter
// circular buffer of DEPTH entries, DEPTH a power of two and at least 2

module resp_queue #(
	parameter int DEPTH = 4
) (
	input  logic                     clk,
	input  logic                     arst_n,

	// enqueue side
	input  logic                     enq_val,
	output logic                     enq_rdy,
	input  mem_msg_pkg::resp_msg_t   enq_msg,
	input  sec_pkg::sec_level_t      enq_sec,
	input  logic                     enq_fail,

	// dequeue side
	output logic                     deq_val,
	input  logic                     deq_rdy,
	output mem_msg_pkg::resp_msg_t   deq_msg,
	output sec_pkg::sec_level_t      deq_sec,
	output logic                     deq_fail
);

	localparam int PTR_W   = $clog2(DEPTH);
	localparam int CNT_W   = $clog2(DEPTH + 1);
	// entry packs fail, security level and message
	localparam int ENTRY_W = mem_msg_pkg::RESP_MSG_NBITS + $bits(sec_pkg::sec_level_t) + 1;

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	logic [ENTRY_W-1:0] entry_mem [DEPTH];

	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;

	logic full;
	logic empty;
	logic push;
	logic pop;

	//==================================================
	// status and handshakes
	//==================================================

	// status comes only from the registered count
	assign full  = (count == cnt_t'(DEPTH));
	assign empty = (count == '0);

	assign enq_rdy = !full;
	assign deq_val = !empty;

	assign push = enq_val && enq_rdy;
	assign pop  = deq_val && deq_rdy;

	// pointers wrap on their own since DEPTH is a power of two
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// entry storage
	always_ff @(posedge clk) begin
		if (push)
			entry_mem[wr_ptr] <= {enq_fail, enq_sec, enq_msg};
	end

	// head entry straight from the storage flops
	assign {deq_fail, deq_sec, deq_msg} = entry_mem[rd_ptr];

	//==================================================
	// checks
	//==================================================

	// a push while full would overwrite the head entry
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> count < cnt_t'(DEPTH))
		else $error("enqueue into a full response queue");

	a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> count != '0)
		else $error("dequeue from an empty response queue");

	a_count_bound: assert property (@(posedge clk) disable iff (!arst_n)
		count <= cnt_t'(DEPTH))
		else $error("response queue count above depth");

endmodule

// ==== design/resp_ingress.sv ====
// network-side input register for memory responses
// two-slot skid pipe so net_resp_rdy comes straight from a flop

module resp_ingress (
	input  logic                     clk,
	input  logic                     arst_n,

	// from the network
	input  logic                     net_resp_val,
	output logic                     net_resp_rdy,
	input  mem_msg_pkg::resp_msg_t   net_resp_msg,
	input  sec_pkg::sec_level_t      net_resp_sec,
	input  logic                     net_resp_fail,

	// toward the response queue
	output logic                     enq_val,
	input  logic                     enq_rdy,
	output mem_msg_pkg::resp_msg_t   enq_msg,
	output sec_pkg::sec_level_t      enq_sec,
	output logic                     enq_fail
);

	// main slot drives enq, skid slot catches one extra beat on a stall
	logic                   main_val;
	mem_msg_pkg::resp_msg_t main_msg;
	sec_pkg::sec_level_t    main_sec;
	logic                   main_fail;

	logic                   skid_val;
	mem_msg_pkg::resp_msg_t skid_msg;
	sec_pkg::sec_level_t    skid_sec;
	logic                   skid_fail;

	logic net_fire;
	logic main_load;
	logic skid_load;

	// accept from the network only while the skid slot is free
	assign net_resp_rdy = !skid_val;
	assign net_fire     = net_resp_val && net_resp_rdy;

	// main slot can take new data when empty or draining this cycle
	assign main_load = !main_val || enq_rdy;
	// a stalled main slot pushes the incoming beat into the skid slot
	assign skid_load = main_val && !enq_rdy && !skid_val;

	//==================================================
	// slot valid flags
	//==================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			main_val <= 1'b0;
			skid_val <= 1'b0;
		end else if (main_load) begin
			// skid beat is older, so it goes first
			if (skid_val) begin
				main_val <= 1'b1;
				skid_val <= 1'b0;
			end else begin
				main_val <= net_fire;
			end
		end else if (net_fire) begin
			skid_val <= 1'b1;
		end
	end

	// payload slots
	always_ff @(posedge clk) begin
		if (main_load) begin
			main_msg  <= skid_val ? skid_msg  : net_resp_msg;
			main_sec  <= skid_val ? skid_sec  : net_resp_sec;
			main_fail <= skid_val ? skid_fail : net_resp_fail;
		end
		if (skid_load) begin
			skid_msg  <= net_resp_msg;
			skid_sec  <= net_resp_sec;
			skid_fail <= net_resp_fail;
		end
	end

	assign enq_val  = main_val;
	assign enq_msg  = main_msg;
	assign enq_sec  = main_sec;
	assign enq_fail = main_fail;

	// a stalled beat stays offered with the same payload until the queue takes it
	a_enq_hold: assert property (@(posedge clk) disable iff (!arst_n)
		enq_val && !enq_rdy |=>
			enq_val && $stable(enq_msg) && $stable(enq_sec) && $stable(enq_fail))
		else $error("ingress changed a stalled response");

endmodule

// ==== design/sec_pkg.sv ====
// security level definitions for the access filter and its testbench
// single-bit lattice where the higher value is the more privileged level

package sec_pkg;

	// one bit security level
	typedef logic sec_level_t;

	// named levels
	localparam sec_level_t SEC_NORMAL = 1'b0;
	localparam sec_level_t SEC_SECURE = 1'b1;

	//==================================================
	// status counter
	//==================================================

	// number of responses whose data was withheld
	// saturates at all ones instead of wrapping
	typedef logic [15:0] deny_count_t;

endpackage

// ==== design/mem_msg_pkg.sv ====
// memory response message layout shared by the response path and its testbench
// modules refer to these types by scoped name, e.g. mem_msg_pkg::resp_msg_t

package mem_msg_pkg;

	//==================================================
	// field types
	//==================================================

	// response type (read, write, init, ...), carried through untouched
	typedef logic [2:0]  resp_type_t;

	// opaque tag used by the processor to match a response to its request
	typedef logic [7:0]  opaque_t;

	// byte length code of the access
	typedef logic [1:0]  len_t;

	// response payload
	typedef logic [31:0] data_t;

	//==================================================
	// response message
	//==================================================

	// field order from msb down: type, opaque, len, data
	typedef struct packed {
		resp_type_t msg_type;
		opaque_t    opaque;
		len_t       len;
		data_t      data;
	} resp_msg_t;

	// total message width, used to size storage
	localparam int RESP_MSG_NBITS = $bits(resp_msg_t);

endpackage
